//--- verilog/axi_lat_settings.svh
`ifndef AXI_LAT_SETTINGS_SVH
`define AXI_LAT_SETTINGS_SVH

// Bus widths
`define AXI_ADDR_W 8
`define AXI_DATA_W 16
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_ID_W 4
`define AXI_LEN_W 8

// Storage depth in words
`define MEM_DEPTH 128

// Channel delays in cycles
// Zero turns a stage into a plain pass-through
`define AW_LATENCY 3
`define W_LATENCY 2
`define AR_LATENCY 4
`define B_LATENCY 5

`endif

//--- verilog/axi_chan_pkg.sv
`include "axi_lat_settings.svh"

package axi_chan_pkg;

  // Only OKAY is ever returned
  localparam logic [1:0] axi_resp_okay = 2'b00;

  // Address request shared by AW and AR
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
  } axi_req_t;

  // One write beat
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_wbeat_t;

  // Write response
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } axi_bresp_t;

  // One read beat
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } axi_rbeat_t;

endpackage

//--- verilog/mem_pkg.sv
`include "axi_lat_settings.svh"

package mem_pkg;

  // Word index is the byte address without the lane bits
  typedef logic [$clog2(`MEM_DEPTH)-1:0] word_idx_t;

  // Written lane by lane and read as a whole word
  typedef union packed {
    logic [`AXI_DATA_W-1:0]      word;
    logic [`AXI_STRB_W-1:0][7:0] bytes;
  } mem_word_u;

  // Write sequencer
  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  // Read sequencer
  typedef enum logic [1:0] {
    rd_idle,
    rd_fetch,
    rd_send
  } rd_state_e;

endpackage

//--- verilog/chan_delay.sv
`timescale 1ns/1ps
`include "axi_lat_settings.svh"

module chan_delay #(
  parameter int  LATENCY   = 1,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  generate
    if (LATENCY == 0) begin : g_pass
      // Handshake goes straight through with no delay
      assign out_valid = in_valid;
      assign out_data  = in_data;
      assign in_ready  = out_ready;

    end else begin : g_delay
      // Counter only needs to reach LATENCY-1
      localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

      typedef enum logic [1:0] {
        dly_idle,
        dly_wait,
        dly_offer
      } dly_state_e;

      dly_state_e       state;
      logic [CNT_W-1:0] cnt;
      payload_t         hold;

      assign in_ready  = (state == dly_idle);
      assign out_valid = (state == dly_offer);
      assign out_data  = hold;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          state <= dly_idle;
          cnt   <= '0;
        end else begin
          case (state)
            dly_idle: begin
              if (in_valid) begin
                state <= dly_wait;
                cnt   <= CNT_W'(LATENCY - 1);
              end
            end
            dly_wait: begin
              if (cnt == '0) begin
                state <= dly_offer;
              end else begin
                cnt <= cnt - 1'b1;
              end
            end
            dly_offer: begin
              if (out_ready) begin
                state <= dly_idle;
              end
            end
            default: state <= dly_idle;
          endcase
        end
      end

      // Item captured once per accept
      always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
          hold <= in_data;
        end
      end

      // Item offered exactly LATENCY cycles after the accept
      out_after_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> !out_valid [*LATENCY] ##1 out_valid);
    end
  endgenerate

endmodule

//--- verilog/mem_array.sv
`timescale 1ns/1ps
`include "axi_lat_settings.svh"

module mem_array (
  input  logic                   clk,
  input  logic                   we,
  input  logic [`AXI_STRB_W-1:0] strb,
  input  mem_pkg::word_idx_t     widx,
  input  logic [`AXI_DATA_W-1:0] wdata,
  input  mem_pkg::word_idx_t     ridx,
  output logic [`AXI_DATA_W-1:0] rdata
);
  import mem_pkg::*;

  mem_word_u mem [`MEM_DEPTH];
  mem_word_u wr_word;

  // Incoming data viewed lane by lane
  assign wr_word.word = wdata;

  // Byte lanes merge under the strobe
  always_ff @(posedge clk) begin
    if (we) begin
      for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
        if (strb[lane]) begin
          mem[widx].bytes[lane] <= wr_word.bytes[lane];
        end
      end
    end
  end

  // Registered read one cycle after ridx
  always_ff @(posedge clk) begin
    rdata <= mem[ridx].word;
  end

endmodule

//--- verilog/mem_ctrl.sv
`timescale 1ns/1ps
`include "axi_lat_settings.svh"

module mem_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     aw_valid,
  input  axi_chan_pkg::axi_req_t   aw_req,
  output logic                     aw_ready,
  input  logic                     w_valid,
  input  axi_chan_pkg::axi_wbeat_t w_beat,
  output logic                     w_ready,
  output logic                     b_valid,
  output axi_chan_pkg::axi_bresp_t b_resp,
  input  logic                     b_ready,
  input  logic                     ar_valid,
  input  axi_chan_pkg::axi_req_t   ar_req,
  output logic                     ar_ready,
  output logic                     r_valid,
  output axi_chan_pkg::axi_rbeat_t r_beat,
  input  logic                     r_ready,
  output logic                     mem_we,
  output logic [`AXI_STRB_W-1:0]   mem_strb,
  output mem_pkg::word_idx_t       mem_widx,
  output logic [`AXI_DATA_W-1:0]   mem_wdata,
  output mem_pkg::word_idx_t       mem_ridx,
  input  logic [`AXI_DATA_W-1:0]   mem_rdata
);
  import axi_chan_pkg::*;
  import mem_pkg::*;

  localparam int LANE_W = $clog2(`AXI_STRB_W);
  localparam int IDX_W  = $bits(word_idx_t);

  wr_state_e              wr_state;
  logic [`AXI_ID_W-1:0]   wr_id;
  word_idx_t              wr_idx;
  logic [`AXI_LEN_W-1:0]  wr_cnt;

  rd_state_e              rd_state;
  logic [`AXI_ID_W-1:0]   rd_id;
  word_idx_t              rd_idx;
  logic [`AXI_LEN_W-1:0]  rd_cnt;
  logic                   rd_first;
  logic [`AXI_DATA_W-1:0] rd_hold;

  logic aw_fire;
  logic w_fire;
  logic ar_fire;
  logic r_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign ar_fire = ar_valid && ar_ready;
  assign r_fire  = r_valid && r_ready;

  // ========================================================================
  // Write sequencer
  // ========================================================================
  assign aw_ready = (wr_state == wr_idle);
  assign w_ready  = (wr_state == wr_data);
  assign b_valid  = (wr_state == wr_resp);
  assign b_resp   = '{id: wr_id, resp: axi_resp_okay};

  // Beat goes into storage on the accept cycle
  assign mem_we    = w_fire;
  assign mem_strb  = w_beat.strb;
  assign mem_widx  = wr_idx;
  assign mem_wdata = w_beat.data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= wr_idle;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (aw_fire) begin
            wr_state <= wr_data;
            wr_cnt   <= aw_req.len;
          end
        end
        wr_data: begin
          if (w_fire) begin
            if (w_beat.last) begin
              wr_state <= wr_resp;
            end else begin
              wr_cnt <= wr_cnt - 1'b1;
            end
          end
        end
        wr_resp: begin
          if (b_ready) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // Index wraps at the top of memory
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_id  <= aw_req.id;
      wr_idx <= aw_req.addr[LANE_W +: IDX_W];
    end else if (w_fire) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  // ========================================================================
  // Read sequencer
  // ========================================================================
  assign ar_ready = (rd_state == rd_idle);
  assign r_valid  = (rd_state == rd_send);
  assign mem_ridx = rd_idx;

  // First send cycle sees fresh storage data and later cycles the held copy
  assign r_beat = '{
    id:   rd_id,
    data: rd_first ? mem_rdata : rd_hold,
    resp: axi_resp_okay,
    last: (rd_cnt == '0)
  };

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= rd_idle;
      rd_cnt   <= '0;
      rd_first <= 1'b0;
    end else begin
      rd_first <= (rd_state == rd_fetch);
      case (rd_state)
        rd_idle: begin
          if (ar_fire) begin
            rd_state <= rd_fetch;
            rd_cnt   <= ar_req.len;
          end
        end
        rd_fetch: rd_state <= rd_send;
        rd_send: begin
          if (r_fire) begin
            if (rd_cnt == '0) begin
              rd_state <= rd_idle;
            end else begin
              rd_state <= rd_fetch;
              rd_cnt   <= rd_cnt - 1'b1;
            end
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_id  <= ar_req.id;
      rd_idx <= ar_req.addr[LANE_W +: IDX_W];
    end else if (r_fire) begin
      rd_idx <= rd_idx + 1'b1;
    end
    if (rd_first) begin
      rd_hold <= mem_rdata;
    end
  end

  // Master's last must line up with the length taken from AW
  w_last_matches_len: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (w_beat.last == (wr_cnt == '0)));

  // Read beat held under back-pressure even if storage changes meanwhile
  r_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r_beat));

endmodule

//--- verilog/axi_mem_latency.sv
`timescale 1ns/1ps
`include "axi_lat_settings.svh"

module axi_mem_latency (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     aw_valid,
  input  axi_chan_pkg::axi_req_t   aw_req,
  output logic                     aw_ready,
  input  logic                     w_valid,
  input  axi_chan_pkg::axi_wbeat_t w_beat,
  output logic                     w_ready,
  input  logic                     ar_valid,
  input  axi_chan_pkg::axi_req_t   ar_req,
  output logic                     ar_ready,
  output logic                     b_valid,
  output axi_chan_pkg::axi_bresp_t b_resp,
  input  logic                     b_ready,
  output logic                     r_valid,
  output axi_chan_pkg::axi_rbeat_t r_beat,
  input  logic                     r_ready
);
  import axi_chan_pkg::*;
  import mem_pkg::*;

  // Delayed request channels into the controller
  logic       dly_aw_valid;
  logic       dly_aw_ready;
  axi_req_t   dly_aw_req;
  logic       dly_w_valid;
  logic       dly_w_ready;
  axi_wbeat_t dly_w_beat;
  logic       dly_ar_valid;
  logic       dly_ar_ready;
  axi_req_t   dly_ar_req;

  // Response from the controller into the B stage
  logic       ctrl_b_valid;
  logic       ctrl_b_ready;
  axi_bresp_t ctrl_b_resp;

  // Storage port
  logic                   mem_we;
  logic [`AXI_STRB_W-1:0] mem_strb;
  word_idx_t              mem_widx;
  logic [`AXI_DATA_W-1:0] mem_wdata;
  word_idx_t              mem_ridx;
  logic [`AXI_DATA_W-1:0] mem_rdata;

  // ========================================================================
  // Request side delays
  // ========================================================================
  chan_delay #(.LATENCY(`AW_LATENCY), .payload_t(axi_req_t)) i_aw_delay (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (aw_valid),
    .in_data  (aw_req),
    .in_ready (aw_ready),
    .out_valid(dly_aw_valid),
    .out_data (dly_aw_req),
    .out_ready(dly_aw_ready)
  );

  chan_delay #(.LATENCY(`W_LATENCY), .payload_t(axi_wbeat_t)) i_w_delay (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (w_valid),
    .in_data  (w_beat),
    .in_ready (w_ready),
    .out_valid(dly_w_valid),
    .out_data (dly_w_beat),
    .out_ready(dly_w_ready)
  );

  chan_delay #(.LATENCY(`AR_LATENCY), .payload_t(axi_req_t)) i_ar_delay (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (ar_valid),
    .in_data  (ar_req),
    .in_ready (ar_ready),
    .out_valid(dly_ar_valid),
    .out_data (dly_ar_req),
    .out_ready(dly_ar_ready)
  );

  // ========================================================================
  // Controller and storage
  // ========================================================================
  mem_ctrl i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (dly_aw_valid),
    .aw_req   (dly_aw_req),
    .aw_ready (dly_aw_ready),
    .w_valid  (dly_w_valid),
    .w_beat   (dly_w_beat),
    .w_ready  (dly_w_ready),
    .b_valid  (ctrl_b_valid),
    .b_resp   (ctrl_b_resp),
    .b_ready  (ctrl_b_ready),
    .ar_valid (dly_ar_valid),
    .ar_req   (dly_ar_req),
    .ar_ready (dly_ar_ready),
    .r_valid  (r_valid),
    .r_beat   (r_beat),
    .r_ready  (r_ready),
    .mem_we   (mem_we),
    .mem_strb (mem_strb),
    .mem_widx (mem_widx),
    .mem_wdata(mem_wdata),
    .mem_ridx (mem_ridx),
    .mem_rdata(mem_rdata)
  );

  // Write response delay on the way out
  chan_delay #(.LATENCY(`B_LATENCY), .payload_t(axi_bresp_t)) i_b_delay (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (ctrl_b_valid),
    .in_data  (ctrl_b_resp),
    .in_ready (ctrl_b_ready),
    .out_valid(b_valid),
    .out_data (b_resp),
    .out_ready(b_ready)
  );

  mem_array i_mem (
    .clk  (clk),
    .we   (mem_we),
    .strb (mem_strb),
    .widx (mem_widx),
    .wdata(mem_wdata),
    .ridx (mem_ridx),
    .rdata(mem_rdata)
  );

endmodule

//--- tb/tb_axi_mem_latency.sv
`timescale 1ns/1ps
`include "axi_lat_settings.svh"

module tb_axi_mem_latency;
  import axi_chan_pkg::*;
  import mem_pkg::*;

  localparam logic [31:0] SEED = 32'h1429f18d;
  localparam int N_TXN       = 40;
  localparam int BEATS_MAX   = 16;
  localparam int INIT_BURSTS = `MEM_DEPTH / BEATS_MAX;
  localparam int LANE_W      = $clog2(`AXI_STRB_W);
  // Worst case of one write plus one read burst with slack for handshakes
  localparam int BURST_CYCLES = `AW_LATENCY + BEATS_MAX * (`W_LATENCY + 3) + `B_LATENCY
                              + `AR_LATENCY + BEATS_MAX * 2 + 8;
  // Factor 4 covers the random ready drops
  localparam int TIMEOUT_CYCLES = 4 * (INIT_BURSTS + N_TXN) * BURST_CYCLES + 16;

  logic       clk;
  logic       rst_n;
  logic       aw_valid;
  axi_req_t   aw_req;
  logic       aw_ready;
  logic       w_valid;
  axi_wbeat_t w_beat;
  logic       w_ready;
  logic       ar_valid;
  axi_req_t   ar_req;
  logic       ar_ready;
  logic       b_valid;
  axi_bresp_t b_resp;
  logic       b_ready;
  logic       r_valid;
  axi_rbeat_t r_beat;
  logic       r_ready;

  // Reference memory with the same lane rule as the storage
  mem_word_u model [`MEM_DEPTH];
  int        error_count = 0;
  int        cycle_count = 0;

  axi_mem_latency i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw_valid(aw_valid),
    .aw_req  (aw_req),
    .aw_ready(aw_ready),
    .w_valid (w_valid),
    .w_beat  (w_beat),
    .w_ready (w_ready),
    .ar_valid(ar_valid),
    .ar_req  (ar_req),
    .ar_ready(ar_ready),
    .b_valid (b_valid),
    .b_resp  (b_resp),
    .b_ready (b_ready),
    .r_valid (r_valid),
    .r_beat  (r_beat),
    .r_ready (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the DUT stopped responding after %0d cycles", cycle_count);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on timeout");
  end

  // ==========================================================================
  // Error reporting and compare tasks
  // ==========================================================================
  task automatic report_error(input string msg);
    error_count++;
    $display("[ERROR] %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bresp(input axi_bresp_t got, input axi_bresp_t exp);
    if (got !== exp) begin
      report_error($sformatf("write response id=%0h resp=%0h, expected id=%0h resp=%0h",
                             got.id, got.resp, exp.id, exp.resp));
    end
  endtask

  task automatic check_rbeat(input axi_rbeat_t got, input axi_rbeat_t exp);
    if (got !== exp) begin
      report_error($sformatf("read beat id=%0h data=%h resp=%0h last=%0b, expected %0h %h %0h %0b",
                             got.id, got.data, got.resp, got.last,
                             exp.id, exp.data, exp.resp, exp.last));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      report_error($sformatf("first read beat after %0d cycles, expected %0d", got, exp));
    end
  endtask

  // ==========================================================================
  // Channel drivers are all called right after a falling edge
  // ==========================================================================
  task automatic send_aw(input axi_req_t req);
    logic taken;
    aw_req   = req;
    aw_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = aw_ready;
      @(negedge clk);
    end
    aw_valid = 1'b0;
  endtask

  task automatic send_wbeat(input axi_wbeat_t beat);
    logic taken;
    w_beat  = beat;
    w_valid = 1'b1;
    taken   = 1'b0;
    while (!taken) begin
      taken = w_ready;
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input axi_req_t req);
    logic taken;
    ar_req   = req;
    ar_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = ar_ready;
      @(negedge clk);
    end
    ar_valid = 1'b0;
  endtask

  task automatic store_model(input word_idx_t idx, input axi_wbeat_t beat);
    mem_word_u incoming;
    incoming.word = beat.data;
    for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
      if (beat.strb[lane]) begin
        model[idx].bytes[lane] = incoming.bytes[lane];
      end
    end
  endtask

  task automatic collect_bresp(input axi_bresp_t exp);
    logic done;
    logic stalled;
    done    = 1'b0;
    stalled = 1'b0;
    while (!done) begin
      b_ready = ($urandom_range(3) != 0);
      if (b_valid) begin
        check_bresp(b_resp, exp);
        done = b_ready;
      end else if (stalled) begin
        report_error("b_valid dropped before the write response was accepted");
      end
      stalled = b_valid && !b_ready;
      @(negedge clk);
    end
    b_ready = 1'b0;
    if (b_valid) begin
      report_error("a second write response followed the accepted one");
    end
  endtask

  task automatic run_write(input axi_req_t req, input logic full_strb);
    axi_wbeat_t beat;
    axi_bresp_t exp;
    word_idx_t  idx;
    idx = word_idx_t'(req.addr >> LANE_W);
    send_aw(req);
    for (int i = 0; i <= req.len; i++) begin
      beat.data = `AXI_DATA_W'($urandom);
      if (full_strb) begin
        beat.strb = '1;
      end else begin
        beat.strb = `AXI_STRB_W'($urandom);
      end
      beat.last = (i == req.len);
      send_wbeat(beat);
      store_model(idx, beat);
      idx = idx + 1'b1;
    end
    exp.id   = req.id;
    exp.resp = axi_resp_okay;
    collect_bresp(exp);
  endtask

  task automatic run_read(input axi_req_t req);
    axi_rbeat_t exp;
    word_idx_t  idx;
    int         beat_no;
    int         wait_cycles;
    logic       stalled;
    idx = word_idx_t'(req.addr >> LANE_W);
    send_ar(req);
    // Read side is idle here so the first beat timing is fixed
    wait_cycles = 0;
    while (!r_valid) begin
      @(negedge clk);
      wait_cycles++;
    end
    check_latency(wait_cycles, `AR_LATENCY + 2);
    beat_no = 0;
    stalled = 1'b0;
    while (beat_no <= req.len) begin
      r_ready = ($urandom_range(3) != 0);
      if (r_valid) begin
        exp.id   = req.id;
        exp.data = model[idx].word;
        exp.resp = axi_resp_okay;
        exp.last = (beat_no == req.len);
        check_rbeat(r_beat, exp);
        if (r_ready) begin
          beat_no++;
          idx = idx + 1'b1;
        end
      end else if (stalled) begin
        report_error("r_valid dropped before the read beat was accepted");
      end
      stalled = r_valid && !r_ready;
      @(negedge clk);
    end
    r_ready = 1'b0;
    if (r_valid) begin
      report_error("an extra read beat followed the last one");
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    axi_req_t req;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw_req   = '0;
    w_valid  = 1'b0;
    w_beat   = '0;
    ar_valid = 1'b0;
    ar_req   = '0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      model[i].word = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Fill every word so no read sees undefined storage
    for (int i = 0; i < INIT_BURSTS; i++) begin
      req.id   = `AXI_ID_W'(i);
      req.addr = `AXI_ADDR_W'(i * BEATS_MAX * `AXI_STRB_W);
      req.len  = `AXI_LEN_W'(BEATS_MAX - 1);
      run_write(req, 1'b1);
    end

    for (int t = 0; t < N_TXN; t++) begin
      req.id   = `AXI_ID_W'($urandom);
      req.addr = `AXI_ADDR_W'($urandom);
      req.len  = `AXI_LEN_W'($urandom_range(BEATS_MAX - 1));
      if ($urandom_range(1) == 1) begin
        run_write(req, 1'b0);
      end else begin
        run_read(req);
      end
    end

    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verilog
verilog/axi_chan_pkg.sv
verilog/mem_pkg.sv
verilog/chan_delay.sv
verilog/mem_array.sv
verilog/mem_ctrl.sv
verilog/axi_mem_latency.sv
tb/tb_axi_mem_latency.sv
